// File: compile.f
+incdir+source
source/datapathPkg.sv
source/isaPkg.sv
source/instrDecoder.sv
source/hazardScoreboard.sv
source/scalarRegFile.sv
source/vectorLane.sv
source/operandLatch.sv
source/decodeTop.sv
test/tbDecode.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
verilator --binary --timing -f compile.f --top-module tbDecode -o tbDecode \
  && ./obj_dir/tbDecode | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }

// File: source/datapathPkg.sv
`include "decode_consts.svh"

package datapathPkg;

  //////////////////////////////
  // Data words
  //////////////////////////////
  typedef logic [`REG_WIDTH-1:0]  regT;   // Scalar register
  typedef logic [`VREG_WIDTH-1:0] vregT;  // Full vector
  typedef logic [`LANE_WIDTH-1:0] laneT;  // One vector lane

  //////////////////////////////
  // Indices and addresses
  //////////////////////////////
  typedef logic [$clog2(`NUM_RF)-1:0]  sRegIdxT;  // Scalar register number
  typedef logic [$clog2(`NUM_VRF)-1:0] vRegIdxT;  // Vector register number

  typedef logic [`PC_WIDTH-1:0] pcT;

endpackage

// File: source/decodeTop.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decodeTop
  import datapathPkg::*;
  import isaPkg::*;
(
  input  logic    I_CLOCK,
  input  logic    reset,
  input  logic    I_LOCK,
  input  pcT      I_PC,
  input  irT      I_IR,
  input  logic    I_FetchStall,
  input  logic    I_WriteBackEnable,
  input  logic    I_VWriteBackEnable,
  input  vRegIdxT I_WriteBackRegIdx,
  input  regT     I_WriteBackData,
  input  vregT    I_VWriteBackData,
  input  laneSelT I_WriteBackLane,
  output logic    O_LOCK,
  output pcT      O_PC,
  output opcodeT  O_Opcode,
  output regT     O_Src1Value,
  output regT     O_Src2Value,
  output regT     O_DestValue,
  output vRegIdxT O_DestRegIdx,
  output vregT    O_VSrc1Value,
  output vregT    O_VSrc2Value,
  output regT     O_Imm,
  output logic    O_FetchStall,
  output logic    O_DepStall,
  output logic    O_DepStallSignal
);

  //////////////////////////////
  // Decoded fields
  //////////////////////////////
  opcodeT  opcode;
  sRegIdxT sSrcA, sSrcB, sStoreSrc, sDest;
  vRegIdxT vSrcA, vSrcB, vDest;
  laneSelT lane;
  immT     imm;
  logic    useSA, useSB, useStore, useVA, useVB;
  logic    writesScalar, writesVector, isStore, isLaneMove;
  logic    issue;
  sRegIdxT storeReadIdx;
  regT     scalarA, scalarB, scalarC;
  laneT [`LANE_COUNT-1:0] laneReadA, laneReadB;

  instrDecoder uDecoder (
    .irIn(I_IR), .opcode(opcode),
    .sSrcA(sSrcA), .sSrcB(sSrcB), .sStoreSrc(sStoreSrc), .sDest(sDest),
    .vSrcA(vSrcA), .vSrcB(vSrcB), .vDest(vDest), .lane(lane), .imm(imm),
    .useSA(useSA), .useSB(useSB), .useStore(useStore), .useVA(useVA), .useVB(useVB),
    .writesScalar(writesScalar), .writesVector(writesVector),
    .isStore(isStore), .isLaneMove(isLaneMove)
  );

  hazardScoreboard uScoreboard (
    .I_CLOCK(I_CLOCK), .reset(reset), .lock(I_LOCK), .fetchStall(I_FetchStall),
    .useSA(useSA), .useSB(useSB), .useStore(useStore), .useVA(useVA), .useVB(useVB),
    .writesScalar(writesScalar), .writesVector(writesVector),
    .sSrcA(sSrcA), .sSrcB(sSrcB), .sStoreSrc(sStoreSrc), .sDest(sDest),
    .vSrcA(vSrcA), .vSrcB(vSrcB), .vDest(vDest),
    .wbScalar(I_WriteBackEnable), .wbVector(I_VWriteBackEnable),
    .wbIdx(I_WriteBackRegIdx), .issue(issue), .depStall(O_DepStallSignal)
  );

  // Third read port carries the store data for STW
  assign storeReadIdx = isStore ? sStoreSrc : sSrcB;

  scalarRegFile uScalarRf (
    .I_CLOCK(I_CLOCK), .reset(reset),
    .wbEnable(I_WriteBackEnable & ~I_VWriteBackEnable),   // Scalar only
    .wbIdx(sRegIdxT'(I_WriteBackRegIdx)), .wbData(I_WriteBackData),
    .readA(sSrcA), .readB(sSrcB), .readC(storeReadIdx),
    .dataA(scalarA), .dataB(scalarB), .dataC(scalarC)
  );

  //////////////////////////////
  // Vector lanes
  //////////////////////////////
  for (genvar g = 0; g < `LANE_COUNT; g++) begin : gLane
    vectorLane #(.laneIndex(g)) uLane (
      .I_CLOCK(I_CLOCK), .reset(reset),
      .wbVector(I_VWriteBackEnable), .wbLaneOnly(I_WriteBackEnable),
      .wbLane(I_WriteBackLane), .wbIdx(I_WriteBackRegIdx),
      .fullData(I_VWriteBackData[g*`LANE_WIDTH +: `LANE_WIDTH]),
      .laneData(I_WriteBackData),
      .readA(vSrcA), .readB(vSrcB),
      .dataA(laneReadA[g]), .dataB(laneReadB[g])
    );
  end

  operandLatch uLatch (
    .I_CLOCK(I_CLOCK), .reset(reset), .lock(I_LOCK), .fetchStall(I_FetchStall),
    .issue(issue), .depStall(O_DepStallSignal), .pc(I_PC), .opcode(opcode),
    .sDest(sDest), .vDest(vDest), .writesVector(writesVector),
    .isLaneMove(isLaneMove), .lane(lane), .imm(imm),
    .scalarA(scalarA), .scalarB(scalarB), .scalarC(scalarC),
    .laneA(laneReadA), .laneB(laneReadB),
    .O_LOCK(O_LOCK), .O_PC(O_PC), .O_Opcode(O_Opcode),
    .O_Src1Value(O_Src1Value), .O_Src2Value(O_Src2Value), .O_DestValue(O_DestValue),
    .O_DestRegIdx(O_DestRegIdx), .O_VSrc1Value(O_VSrc1Value), .O_VSrc2Value(O_VSrc2Value),
    .O_Imm(O_Imm), .O_FetchStall(O_FetchStall), .O_DepStall(O_DepStall)
  );

endmodule

// File: source/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath widths and register counts
`define REG_WIDTH     16
`define NUM_RF        16
`define NUM_VRF       64
`define LANE_COUNT    4
`define LANE_WIDTH    16
`define VREG_WIDTH    64
`define OPCODE_WIDTH  8
`define IR_WIDTH      32
`define PC_WIDTH      16

// Instruction field positions
`define OPC_MSB    31
`define OPC_LSB    24
`define SDEST_MSB  23
`define SDEST_LSB  20
`define SSRC1_MSB  19
`define SSRC1_LSB  16
`define SSRC2_MSB  11
`define SSRC2_LSB  8
`define IMM_MSB    15
`define IMM_LSB    0
`define VDEST_MSB  21
`define VDEST_LSB  16
`define VSRC1_MSB  13
`define VSRC1_LSB  8
`define VSRC2_MSB  5
`define VSRC2_LSB  0
`define LANE_MSB   23
`define LANE_LSB   22

`endif

// File: source/hazardScoreboard.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module hazardScoreboard
  import datapathPkg::*;
(
  input  logic    I_CLOCK,
  input  logic    reset,
  input  logic    lock,
  input  logic    fetchStall,
  input  logic    useSA,
  input  logic    useSB,
  input  logic    useStore,
  input  logic    useVA,
  input  logic    useVB,
  input  logic    writesScalar,
  input  logic    writesVector,
  input  sRegIdxT sSrcA,
  input  sRegIdxT sSrcB,
  input  sRegIdxT sStoreSrc,
  input  sRegIdxT sDest,
  input  vRegIdxT vSrcA,
  input  vRegIdxT vSrcB,
  input  vRegIdxT vDest,
  input  logic    wbScalar,
  input  logic    wbVector,
  input  vRegIdxT wbIdx,
  output logic    issue,
  output logic    depStall
);

  logic [`NUM_RF-1:0]  sValid;  // 1 = no write pending
  logic [`NUM_VRF-1:0] vValid;
  logic    wbScalarOnly;        // Both enables mean a lane write
  sRegIdxT wbScalarIdx;
  logic    hazard;
  logic    active;

  assign wbScalarOnly = wbScalar & ~wbVector;
  assign wbScalarIdx  = sRegIdxT'(wbIdx);  // Low bits pick the scalar

  // Busy unless valid or written back this very cycle
  function automatic logic sBusy(sRegIdxT idx);
    return ~sValid[idx] & ~(wbScalarOnly & (wbScalarIdx == idx));
  endfunction

  function automatic logic vBusy(vRegIdxT idx);
    return ~vValid[idx] & ~(wbVector & (wbIdx == idx));
  endfunction

  //////////////////////////////
  // Hazard and issue
  //////////////////////////////
  always_comb begin
    hazard = (useSA    & sBusy(sSrcA))
           | (useSB    & sBusy(sSrcB))
           | (useStore & sBusy(sStoreSrc))
           | (useVA    & vBusy(vSrcA))
           | (useVB    & vBusy(vSrcB));
  end

  assign active   = lock & ~fetchStall;
  assign issue    = active & ~hazard;
  assign depStall = active & hazard;   // Straight back to fetch

  //////////////////////////////
  // Valid bits
  //////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      sValid <= '1;
      vValid <= '1;
    end else begin
      if (wbScalarOnly) sValid[wbScalarIdx] <= 1'b1;
      if (wbVector)     vValid[wbIdx]       <= 1'b1;  // Full or lane write
      // Later assignment wins, so a new owner beats the writeback
      if (issue && writesScalar) sValid[sDest] <= 1'b0;
      if (issue && writesVector) vValid[vDest] <= 1'b0;
    end
  end

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module instrDecoder
  import datapathPkg::*;
  import isaPkg::*;
(
  input  irT      irIn,
  output opcodeT  opcode,
  output sRegIdxT sSrcA,
  output sRegIdxT sSrcB,
  output sRegIdxT sStoreSrc,
  output sRegIdxT sDest,
  output vRegIdxT vSrcA,
  output vRegIdxT vSrcB,
  output vRegIdxT vDest,
  output laneSelT lane,
  output immT     imm,
  output logic    useSA,
  output logic    useSB,
  output logic    useStore,
  output logic    useVA,
  output logic    useVB,
  output logic    writesScalar,
  output logic    writesVector,
  output logic    isStore,
  output logic    isLaneMove
);

  //////////////////////////////
  // Field slicing
  //////////////////////////////
  assign opcode    = opcodeT'(irIn[`OPC_MSB:`OPC_LSB]);
  assign sSrcA     = irIn[`SSRC1_MSB:`SSRC1_LSB];
  assign sSrcB     = irIn[`SSRC2_MSB:`SSRC2_LSB];
  assign sStoreSrc = irIn[`SDEST_MSB:`SDEST_LSB];   // STW data register
  assign vSrcA     = irIn[`VSRC1_MSB:`VSRC1_LSB];
  assign vSrcB     = irIn[`VSRC2_MSB:`VSRC2_LSB];
  assign vDest     = irIn[`VDEST_MSB:`VDEST_LSB];
  assign lane      = irIn[`LANE_MSB:`LANE_LSB];
  assign imm       = irIn[`IMM_MSB:`IMM_LSB];

  // Moves keep their destination in the first source field
  assign sDest = (opcode == MOV || opcode == MOVI_D) ? irIn[`SSRC1_MSB:`SSRC1_LSB]
                                                     : irIn[`SDEST_MSB:`SDEST_LSB];

  //////////////////////////////
  // Opcode classes
  //////////////////////////////
  always_comb begin
    useSA        = 1'b0;
    useSB        = 1'b0;
    useStore     = 1'b0;
    useVA        = 1'b0;
    useVB        = 1'b0;
    writesScalar = 1'b0;
    writesVector = 1'b0;
    isStore      = 1'b0;
    isLaneMove   = 1'b0;
    case (opcode)
      ADD_D, AND_D: begin
        useSA        = 1'b1;
        useSB        = 1'b1;
        writesScalar = 1'b1;
      end
      ADDI_D, ANDI_D, LDW: begin
        useSA        = 1'b1;  // Base or first operand
        writesScalar = 1'b1;
      end
      MOV: begin
        useSB        = 1'b1;
        writesScalar = 1'b1;
      end
      MOVI_D: writesScalar = 1'b1;
      STW: begin
        useSA    = 1'b1;      // Address base
        useStore = 1'b1;      // Store data
        isStore  = 1'b1;
      end
      VADD: begin
        useVA        = 1'b1;
        useVB        = 1'b1;
        writesVector = 1'b1;
      end
      VMOV: begin
        useVA        = 1'b1;
        writesVector = 1'b1;
      end
      VMOVI: writesVector = 1'b1;
      VCOMPMOV: begin
        useSB        = 1'b1;  // Scalar going into the lane
        writesVector = 1'b1;
        isLaneMove   = 1'b1;
      end
      VCOMPMOVI: begin
        writesVector = 1'b1;
        isLaneMove   = 1'b1;
      end
      default: ;              // Unknown opcode, no sources and no destination
    endcase
  end

endmodule

// File: source/isaPkg.sv
`include "decode_consts.svh"

package isaPkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    ADD_D     = 8'h00,
    ADDI_D    = 8'h01,
    AND_D     = 8'h02,
    ANDI_D    = 8'h03,
    MOV       = 8'h04,
    MOVI_D    = 8'h05,
    LDW       = 8'h06,
    STW       = 8'h07,  // Store, no destination
    VADD      = 8'h10,
    VMOV      = 8'h11,
    VMOVI     = 8'h12,
    VCOMPMOV  = 8'h13,  // Scalar into one lane
    VCOMPMOVI = 8'h14   // Immediate into one lane
  } opcodeT;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  // Whole instruction word
  typedef logic [`IR_WIDTH-1:0] irT;

  // Immediate, already register width
  typedef logic [`IMM_MSB-`IMM_LSB:0] immT;

  // Lane number of a lane move
  typedef logic [`LANE_MSB-`LANE_LSB:0] laneSelT;

endpackage

// File: source/operandLatch.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module operandLatch
  import datapathPkg::*;
  import isaPkg::*;
(
  input  logic    I_CLOCK,
  input  logic    reset,
  input  logic    lock,
  input  logic    fetchStall,
  input  logic    issue,
  input  logic    depStall,
  input  pcT      pc,
  input  opcodeT  opcode,
  input  sRegIdxT sDest,
  input  vRegIdxT vDest,
  input  logic    writesVector,
  input  logic    isLaneMove,
  input  laneSelT lane,
  input  immT     imm,
  input  regT     scalarA,
  input  regT     scalarB,
  input  regT     scalarC,
  input  laneT [`LANE_COUNT-1:0] laneA,  // Lane 0 in the low bits
  input  laneT [`LANE_COUNT-1:0] laneB,
  output logic    O_LOCK,
  output pcT      O_PC,
  output opcodeT  O_Opcode,
  output regT     O_Src1Value,
  output regT     O_Src2Value,
  output regT     O_DestValue,
  output vRegIdxT O_DestRegIdx,
  output vregT    O_VSrc1Value,
  output vregT    O_VSrc2Value,
  output regT     O_Imm,
  output logic    O_FetchStall,
  output logic    O_DepStall
);

  //////////////////////////////
  // Stage status
  //////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      O_LOCK       <= 1'b0;
      O_FetchStall <= 1'b0;
      O_DepStall   <= 1'b0;
    end else begin
      O_LOCK       <= lock;
      O_FetchStall <= fetchStall;
      O_DepStall   <= depStall;  // Held instruction is a bubble downstream
    end
  end

  //////////////////////////////
  // Operands, loaded on issue only
  //////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (issue) begin
      O_PC         <= pc;
      O_Opcode     <= opcode;
      O_Imm        <= regT'(imm);
      O_Src1Value  <= scalarA;
      O_Src2Value  <= scalarB;
      O_DestValue  <= isLaneMove ? regT'(lane) : scalarC;   // Lane number for lane moves
      O_DestRegIdx <= writesVector ? vDest : vRegIdxT'(sDest);
      O_VSrc1Value <= laneA;     // Packed lanes form the vector
      O_VSrc2Value <= laneB;
    end
  end

endmodule

// File: source/scalarRegFile.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module scalarRegFile
  import datapathPkg::*;
(
  input  logic    I_CLOCK,
  input  logic    reset,
  input  logic    wbEnable,
  input  sRegIdxT wbIdx,
  input  regT     wbData,
  input  sRegIdxT readA,
  input  sRegIdxT readB,
  input  sRegIdxT readC,
  output regT     dataA,
  output regT     dataB,
  output regT     dataC
);

  regT regs [`NUM_RF];

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      for (int i = 0; i < `NUM_RF; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEnable) begin
      regs[wbIdx] <= wbData;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Write first, the incoming value bypasses the array
  function automatic regT readPort(sRegIdxT idx);
    if (wbEnable && wbIdx == idx) begin
      return wbData;
    end
    return regs[idx];
  endfunction

  always_comb begin
    dataA = readPort(readA);  // First source
    dataB = readPort(readB);  // Second source
    dataC = readPort(readC);  // Store data or second source
  end

endmodule

// File: source/vectorLane.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module vectorLane
  import datapathPkg::*;
  import isaPkg::*;
#(
  parameter int laneIndex = 0
) (
  input  logic    I_CLOCK,
  input  logic    reset,
  input  logic    wbVector,
  input  logic    wbLaneOnly,   // Single lane write
  input  laneSelT wbLane,
  input  vRegIdxT wbIdx,
  input  laneT    fullData,     // This lane's slice of a full write
  input  laneT    laneData,     // Scalar value for a lane write
  input  vRegIdxT readA,
  input  vRegIdxT readB,
  output laneT    dataA,
  output laneT    dataB
);

  laneT entries [`NUM_VRF];
  logic writeHere;
  laneT writeValue;

  // Full writes hit every lane, lane writes only the selected one
  assign writeHere  = wbVector & (~wbLaneOnly | (wbLane == laneSelT'(laneIndex)));
  assign writeValue = wbLaneOnly ? laneData : fullData;

  always_ff @(posedge I_CLOCK) begin
    if (reset) begin
      for (int i = 0; i < `NUM_VRF; i++) begin
        entries[i] <= '0;
      end
    end else if (writeHere) begin
      entries[wbIdx] <= writeValue;
    end
  end

  // Same cycle forwarding
  assign dataA = (writeHere && wbIdx == readA) ? writeValue : entries[readA];
  assign dataB = (writeHere && wbIdx == readB) ? writeValue : entries[readB];

endmodule

// File: test/tbDecode.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module tbDecode
  import datapathPkg::*;
  import isaPkg::*;
();

  localparam int NUM_INSTR   = 2000;
  localparam int CYCLE_LIMIT = NUM_INSTR * 3 / 2;  // Room for stalls and reset
  localparam int VREG_SPAN   = 8;                  // Few vector regs, more overlap

  logic    I_CLOCK = 1'b0;
  logic    reset;
  logic    I_LOCK;
  pcT      I_PC;
  irT      I_IR;
  logic    I_FetchStall;
  logic    I_WriteBackEnable;
  logic    I_VWriteBackEnable;
  vRegIdxT I_WriteBackRegIdx;
  regT     I_WriteBackData;
  vregT    I_VWriteBackData;
  laneSelT I_WriteBackLane;
  logic    O_LOCK, O_FetchStall, O_DepStall, O_DepStallSignal;
  pcT      O_PC;
  opcodeT  O_Opcode;
  regT     O_Src1Value, O_Src2Value, O_DestValue, O_Imm;
  vRegIdxT O_DestRegIdx;
  vregT    O_VSrc1Value, O_VSrc2Value;

  decodeTop DUT (.*);

  always #4 I_CLOCK = ~I_CLOCK;  // 8 ns period

  //////////////////////////////
  // Reference model state
  //////////////////////////////
  regT  mRegs   [`NUM_RF];
  vregT mVRegs  [`NUM_VRF];
  logic mSValid [`NUM_RF];
  logic mVValid [`NUM_VRF];
  logic [7:0] mOpc;                         // Decoded view of the current instruction
  sRegIdxT mSA, mSB, mSSt, mSD;
  vRegIdxT mVA, mVB, mVD;
  laneSelT mLane;
  logic mUseSA, mUseSB, mUseSt, mUseVA, mUseVB, mWrS, mWrV, mStore, mLaneMove;
  logic expLock, expFetch, expDep;          // Expected registered outputs
  pcT   expPc;
  logic [7:0] expOpc;
  regT  expImm, expSrc1, expSrc2, expDest;
  vRegIdxT expDestIdx;
  vregT expV1, expV2;
  irT   curIr;                              // Held until it issues
  pcT   curPc;
  logic [31:0] lcgState = 32'd2083;
  int   errorCount, issuedCount, cycleCount;
  logic anyIssued;
  logic [7:0] opList [13] = '{ADD_D, ADDI_D, AND_D, ANDI_D, MOV, MOVI_D, LDW, STW,
                              VADD, VMOV, VMOVI, VCOMPMOV, VCOMPMOVI};

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int randBelow(int n);
    return int'(nextRand() >> 8) % n;  // Upper bits, better spread
  endfunction

  task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      errorCount++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic makeInstruction();
    logic [7:0] opc;
    opc   = opList[randBelow(13)];
    curIr = nextRand();
    curPc = pcT'(nextRand());
    curIr[`OPC_MSB:`OPC_LSB] = opc;
    if (opc >= 8'h10) begin
      curIr[`VDEST_MSB:`VDEST_LSB] = vRegIdxT'(randBelow(VREG_SPAN));
      if (opc == VADD || opc == VMOV || opc == VMOVI) begin
        curIr[`VSRC1_MSB:`VSRC1_LSB] = vRegIdxT'(randBelow(VREG_SPAN));
        curIr[`VSRC2_MSB:`VSRC2_LSB] = vRegIdxT'(randBelow(VREG_SPAN));
      end
    end
  endtask

  task automatic writeScalar(sRegIdxT idx);
    I_WriteBackEnable = 1'b1;
    I_WriteBackRegIdx = {2'(randBelow(4)), idx};  // Upper bits must be ignored
  endtask

  task automatic writeVector(vRegIdxT idx);
    I_VWriteBackEnable = 1'b1;
    I_WriteBackEnable  = (randBelow(2) == 0);     // Half are lane writes
    I_WriteBackRegIdx  = idx;
  endtask

  task automatic pickWriteback();
    int start;
    int idx;
    I_WriteBackEnable  = 1'b0;
    I_VWriteBackEnable = 1'b0;
    I_WriteBackData    = regT'(nextRand());
    I_VWriteBackData   = {nextRand(), nextRand()};
    I_WriteBackLane    = laneSelT'(randBelow(4));
    I_WriteBackRegIdx  = vRegIdxT'(randBelow(`NUM_VRF));
    if (randBelow(4) == 0) return;
    // Mostly release a source the current instruction waits on
    if (mUseSA && !mSValid[mSA]) begin
      writeScalar(mSA);
    end else if (mUseSB && !mSValid[mSB]) begin
      writeScalar(mSB);
    end else if (mUseSt && !mSValid[mSSt]) begin
      writeScalar(mSSt);
    end else if (mUseVA && !mVValid[mVA]) begin
      writeVector(mVA);
    end else if (mUseVB && !mVValid[mVB]) begin
      writeVector(mVB);
    end else if (randBelow(2) == 0) begin
      start = randBelow(`NUM_RF);
      idx   = start;
      for (int i = 0; i < `NUM_RF; i++) begin
        if (!mSValid[(start + i) % `NUM_RF]) idx = (start + i) % `NUM_RF;  // Pending one
      end
      writeScalar(sRegIdxT'(idx));
    end else begin
      start = randBelow(VREG_SPAN);
      idx   = start;
      for (int i = 0; i < VREG_SPAN; i++) begin
        if (!mVValid[(start + i) % VREG_SPAN]) idx = (start + i) % VREG_SPAN;
      end
      writeVector(vRegIdxT'(idx));
    end
  endtask

  //////////////////////////////
  // Model behavior
  //////////////////////////////
  task automatic decodeModel(irT ir);
    mOpc  = ir[`OPC_MSB:`OPC_LSB];
    mSA   = ir[`SSRC1_MSB:`SSRC1_LSB];
    mSB   = ir[`SSRC2_MSB:`SSRC2_LSB];
    mSSt  = ir[`SDEST_MSB:`SDEST_LSB];
    mVA   = ir[`VSRC1_MSB:`VSRC1_LSB];
    mVB   = ir[`VSRC2_MSB:`VSRC2_LSB];
    mVD   = ir[`VDEST_MSB:`VDEST_LSB];
    mLane = ir[`LANE_MSB:`LANE_LSB];
    mSD   = (mOpc == MOV || mOpc == MOVI_D) ? mSA : mSSt;  // Moves use 19:16
    {mUseSA, mUseSB, mUseSt, mUseVA, mUseVB} = '0;
    {mWrS, mWrV, mStore, mLaneMove} = '0;
    case (mOpc)
      ADD_D, AND_D: {mUseSA, mUseSB, mWrS} = '1;
      ADDI_D, ANDI_D, LDW: {mUseSA, mWrS} = '1;
      MOV: {mUseSB, mWrS} = '1;
      MOVI_D: mWrS = 1'b1;
      STW: {mUseSA, mUseSt, mStore} = '1;
      VADD: {mUseVA, mUseVB, mWrV} = '1;
      VMOV: {mUseVA, mWrV} = '1;
      VMOVI: mWrV = 1'b1;
      VCOMPMOV: {mUseSB, mWrV, mLaneMove} = '1;
      VCOMPMOVI: {mWrV, mLaneMove} = '1;
      default: ;
    endcase
  endtask

  // Writeback lands before the read, as the DUT forwards it
  task automatic applyWriteback();
    if (I_WriteBackEnable && !I_VWriteBackEnable) begin
      mRegs[I_WriteBackRegIdx[3:0]]   = I_WriteBackData;
      mSValid[I_WriteBackRegIdx[3:0]] = 1'b1;
    end else if (I_VWriteBackEnable) begin
      if (I_WriteBackEnable) begin
        mVRegs[I_WriteBackRegIdx][I_WriteBackLane*`LANE_WIDTH +: `LANE_WIDTH] = I_WriteBackData;
      end else begin
        mVRegs[I_WriteBackRegIdx] = I_VWriteBackData;
      end
      mVValid[I_WriteBackRegIdx] = 1'b1;  // Lane write also releases it
    end
  endtask

  task automatic driveCycle();
    logic hazard;
    logic active;
    I_LOCK       = (randBelow(32) != 0);
    I_FetchStall = (randBelow(32) == 0);
    I_PC         = curPc;
    I_IR         = curIr;
    decodeModel(curIr);
    pickWriteback();
    applyWriteback();
    hazard = (mUseSA && !mSValid[mSA]) || (mUseSB && !mSValid[mSB])
          || (mUseSt && !mSValid[mSSt]) || (mUseVA && !mVValid[mVA])
          || (mUseVB && !mVValid[mVB]);
    active   = I_LOCK && !I_FetchStall;
    expLock  = I_LOCK;
    expFetch = I_FetchStall;
    expDep   = active && hazard;
    #1;
    checkValue("O_DepStallSignal", 64'(expDep), 64'(O_DepStallSignal));
    if (active && !hazard) begin
      expPc      = curPc;
      expOpc     = mOpc;
      expImm     = curIr[`IMM_MSB:`IMM_LSB];
      expSrc1    = mRegs[mSA];
      expSrc2    = mRegs[mSB];
      expDest    = mLaneMove ? regT'(mLane) : (mStore ? mRegs[mSSt] : mRegs[mSB]);
      expDestIdx = mWrV ? mVD : {2'b00, mSD};
      expV1      = mVRegs[mVA];
      expV2      = mVRegs[mVB];
      if (mWrS) mSValid[mSD] = 1'b0;     // Clear after the set, so it wins
      if (mWrV) mVValid[mVD] = 1'b0;
      issuedCount++;
      anyIssued = 1'b1;
      makeInstruction();
    end
  endtask

  task automatic checkOutputs();
    checkValue("O_LOCK", 64'(expLock), 64'(O_LOCK));
    checkValue("O_FetchStall", 64'(expFetch), 64'(O_FetchStall));
    checkValue("O_DepStall", 64'(expDep), 64'(O_DepStall));
    if (anyIssued) begin  // Operands hold between issues
      checkValue("O_PC", 64'(expPc), 64'(O_PC));
      checkValue("O_Opcode", 64'(expOpc), 64'(O_Opcode));
      checkValue("O_Imm", 64'(expImm), 64'(O_Imm));
      checkValue("O_Src1Value", 64'(expSrc1), 64'(O_Src1Value));
      checkValue("O_Src2Value", 64'(expSrc2), 64'(O_Src2Value));
      checkValue("O_DestValue", 64'(expDest), 64'(O_DestValue));
      checkValue("O_DestRegIdx", 64'(expDestIdx), 64'(O_DestRegIdx));
      checkValue("O_VSrc1Value", expV1, O_VSrc1Value);
      checkValue("O_VSrc2Value", expV2, O_VSrc2Value);
    end
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////
  always @(posedge I_CLOCK) begin
    cycleCount++;
    if (cycleCount == CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with only %0d instructions issued",
               cycleCount, issuedCount);
      $display("Errors: %0d", errorCount);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    {I_WriteBackEnable, I_VWriteBackEnable} = '0;
    I_LOCK       = 1'b1;   // High under reset, only reset keeps the status outputs low
    I_FetchStall = 1'b1;
    I_PC = '0;
    I_IR = '0;
    I_WriteBackRegIdx = '0;
    I_WriteBackData   = '0;
    I_VWriteBackData  = '0;
    I_WriteBackLane   = '0;
    errorCount  = 0;
    issuedCount = 0;
    cycleCount  = 0;
    anyIssued   = 1'b0;
    {expLock, expFetch, expDep} = '0;
    for (int i = 0; i < `NUM_RF; i++) begin
      mRegs[i]   = '0;
      mSValid[i] = 1'b1;
    end
    for (int i = 0; i < `NUM_VRF; i++) begin
      mVRegs[i]  = '0;
      mVValid[i] = 1'b1;
    end
    makeInstruction();
    repeat (8) @(posedge I_CLOCK);
    @(negedge I_CLOCK);
    checkOutputs();        // Status outputs cleared by reset
    reset = 1'b0;
    while (issuedCount < NUM_INSTR) begin
      driveCycle();
      @(negedge I_CLOCK);
      checkOutputs();
    end
    $display("Errors: %0d in %0d instructions over %0d cycles",
             errorCount, issuedCount, cycleCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
